// ==== logic/classifier_settings.svh ====
`ifndef CLASSIFIER_SETTINGS_SVH
`define CLASSIFIER_SETTINGS_SVH

// Layer sizes
`define NUM_FEATURES 10
`define NUM_HIDDEN 6
`define NUM_CLASSES 4

// Data widths
`define ACT_WIDTH 8
`define WEIGHT_WIDTH 8
`define BIAS_WIDTH 16
`define SUM_WIDTH 23
`define CLASS_IDX_WIDTH 2

// Input register, sum register, output register
`define NODE_LATENCY 3

`endif

// ==== logic/nnTypesPkg.sv ====
`include "classifier_settings.svh"

package nnTypesPkg;

	// One input feature, two's complement
	typedef logic signed [`ACT_WIDTH-1:0] feature_t;

	// Rectified activation out of a neuron, 0 to 128
	typedef logic [`ACT_WIDTH-1:0] act_t;

	typedef logic [`CLASS_IDX_WIDTH-1:0] classIdx_t;

	// Element 0 sits in the low bits
	typedef feature_t [`NUM_FEATURES-1:0] featureVec_t;

	typedef act_t [`NUM_HIDDEN-1:0] hiddenVec_t;

	typedef act_t [`NUM_CLASSES-1:0] scoreVec_t;

	// Winning class and the score it won with
	typedef struct packed
	{
		classIdx_t classIdx;
		act_t classScore;
	} classResult_t;

endpackage

// ==== logic/nnWeightsPkg.sv ====
`include "classifier_settings.svh"

package nnWeightsPkg;

	// Row n holds the weights of hidden node n, column i the weight of feature i
	localparam logic [0:`NUM_HIDDEN-1][0:`NUM_FEATURES-1][`WEIGHT_WIDTH-1:0] hiddenWeights =
	{
		{ 8'sd12,  -8'sd7,  8'sd25,   8'sd3, -8'sd18,
		   8'sd9,  8'sd30,  -8'sd4,  8'sd15, -8'sd22},
		{-8'sd20,  8'sd17,   8'sd6, -8'sd29,  8'sd11,
		  8'sd24,  -8'sd3,   8'sd8, -8'sd14,  8'sd19},
		{ 8'sd27,   8'sd5, -8'sd16,  8'sd21,  -8'sd9,
		  -8'sd2,  8'sd13,  8'sd18, -8'sd25,   8'sd7},
		{ -8'sd6, -8'sd23,  8'sd10,  8'sd14,  8'sd29,
		 -8'sd15,   8'sd4, -8'sd11,  8'sd22,  8'sd16},
		{  8'sd9,  8'sd28, -8'sd19,  -8'sd5,   8'sd7,
		  8'sd12, -8'sd27,  8'sd20,   8'sd3, -8'sd13},
		{-8'sd31,   8'sd8,  8'sd18,  8'sd26, -8'sd12,
		   8'sd5,  8'sd16, -8'sd21,  8'sd11,   8'sd2}
	};

	localparam logic [0:`NUM_HIDDEN-1][`BIAS_WIDTH-1:0] hiddenBias =
	{
		-16'sd512,
		16'sd256,
		16'sd0,
		-16'sd128,
		16'sd384,
		-16'sd256
	};

	// Row n holds the weights of output node n over the hidden activations
	localparam logic [0:`NUM_CLASSES-1][0:`NUM_HIDDEN-1][`WEIGHT_WIDTH-1:0] outWeights =
	{
		{ 8'sd21, -8'sd14,   8'sd9,  8'sd17,  -8'sd8,  8'sd12},
		{-8'sd10,  8'sd23,  8'sd15,  -8'sd6,  8'sd19,  -8'sd3},
		{  8'sd7,  8'sd11, -8'sd18,  8'sd25,   8'sd4,  8'sd16},
		{ 8'sd14,  -8'sd5,  8'sd20, -8'sd12,  8'sd13,   8'sd8}
	};

	localparam logic [0:`NUM_CLASSES-1][`BIAS_WIDTH-1:0] outBias =
	{
		16'sd128,
		-16'sd64,
		16'sd0,
		16'sd192
	};

endpackage

// ==== logic/featureCapture.sv ====
`timescale 1ns/1ps
`include "classifier_settings.svh"

module featureCapture
	import nnTypesPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inVld,
	input featureVec_t inVec,
	output logic capVld,
	output featureVec_t capVec
);

	// Pins see one flop only, the multiplier array sits behind it
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			capVld <= 1'b0;
		end
		else
		begin
			capVld <= inVld;
		end
	end

	// Vector moves every cycle, strobe says when it counts
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			capVec <= '0;
		end
		else
		begin
			capVec <= inVec;
		end
	end

	// An X on the strobe would spread through every layer's valid pipe
	inVldKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(inVld))
		else $error("inVld is unknown after reset");

endmodule

// ==== logic/neuronNode.sv ====
`timescale 1ns/1ps
`include "classifier_settings.svh"

module neuronNode #(
	parameter int NUM_IN = `NUM_FEATURES,
	parameter logic [0:NUM_IN-1][`WEIGHT_WIDTH-1:0] WEIGHTS = '0,
	parameter logic signed [`BIAS_WIDTH-1:0] BIAS = '0
) (
	input logic clk,
	input logic reset,
	input logic [NUM_IN-1:0][`ACT_WIDTH-1:0] act,
	output logic [`ACT_WIDTH-1:0] node
);

	// Activation is sum / 64, so bit 5 is the rounding bit
	localparam int SHIFT = 6;
	localparam int SAT_LSB = SHIFT + `ACT_WIDTH - 1;
	localparam logic [`ACT_WIDTH-1:0] SAT_VALUE = {1'b0, {(`ACT_WIDTH-1){1'b1}}};

	logic [NUM_IN-1:0][`ACT_WIDTH-1:0] actReg;
	logic signed [`SUM_WIDTH-1:0] sumNext;
	logic signed [`SUM_WIDTH-1:0] sumReg;
	logic [`ACT_WIDTH-1:0] nodeNext;

	// Inputs are two's complement bytes, an activation of 128 reads as -128
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < NUM_IN; i++)
		begin
			sumNext = sumNext + $signed(actReg[i]) * $signed(WEIGHTS[i]);
		end
	end

	// Rectify, saturate, then round half up
	always_comb
	begin
		if (sumReg[`SUM_WIDTH-1])
		begin
			nodeNext = '0;
		end
		else if (sumReg[`SUM_WIDTH-2:SAT_LSB] != '0)
		begin
			nodeNext = SAT_VALUE;
		end
		else
		begin
			// Sums 8160..8191 round up to 128
			nodeNext = sumReg[SAT_LSB:SHIFT] + sumReg[SHIFT-1];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			node <= '0;
		end
		else
		begin
			actReg <= act;
			sumReg <= sumNext;
			node <= nodeNext;
		end
	end

	nodeRange: assert property (@(posedge clk) disable iff (reset)
		node <= SAT_VALUE + 1'b1)
		else $error("neuron output %0d above 128", node);

endmodule

// ==== logic/denseLayer.sv ====
`timescale 1ns/1ps
`include "classifier_settings.svh"

module denseLayer
	import nnWeightsPkg::*;
#(
	parameter int NUM_IN = `NUM_FEATURES,
	parameter int NUM_OUT = `NUM_HIDDEN,
	// 0 picks the hidden tables, 1 the output tables
	parameter bit OUT_LAYER = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic layerVldIn,
	input logic [NUM_IN-1:0][`ACT_WIDTH-1:0] layerIn,
	output logic layerVldOut,
	output logic [NUM_OUT-1:0][`ACT_WIDTH-1:0] layerOut
);

	logic [`NODE_LATENCY-1:0] vldPipe;

	// Strobe follows the data through the node pipeline
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vldPipe <= '0;
		end
		else
		begin
			vldPipe <= {vldPipe[`NODE_LATENCY-2:0], layerVldIn};
		end
	end

	assign layerVldOut = vldPipe[`NODE_LATENCY-1];

	for (genvar n = 0; n < NUM_OUT; n++)
	begin : gNode
		if (OUT_LAYER)
		begin : gOut
			neuronNode #(
				.NUM_IN(NUM_IN),
				.WEIGHTS(outWeights[n]),
				.BIAS(outBias[n])
			) uNode (
				.clk(clk),
				.reset(reset),
				.act(layerIn),
				.node(layerOut[n])
			);
		end
		else
		begin : gHid
			neuronNode #(
				.NUM_IN(NUM_IN),
				.WEIGHTS(hiddenWeights[n]),
				.BIAS(hiddenBias[n])
			) uNode (
				.clk(clk),
				.reset(reset),
				.act(layerIn),
				.node(layerOut[n])
			);
		end
	end

endmodule

// ==== logic/argmaxSelect.sv ====
`timescale 1ns/1ps
`include "classifier_settings.svh"

module argmaxSelect
	import nnTypesPkg::*;
(
	input logic clk,
	input logic reset,
	input logic scoreVld,
	input scoreVec_t scoreVec,
	output logic outVld,
	output scoreVec_t outScores,
	output classResult_t outResult
);

	classResult_t best;
	logic betterScore;

	// Strict greater-than keeps the lowest index on a tie
	always_comb
	begin
		best.classIdx = '0;
		best.classScore = scoreVec[0];
		for (int i = 1; i < `NUM_CLASSES; i++)
		begin
			if (scoreVec[i] > best.classScore)
			begin
				best.classIdx = classIdx_t'(i);
				best.classScore = scoreVec[i];
			end
		end
	end

	// Scores registered alongside so they line up with the result
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outVld <= 1'b0;
			outScores <= '0;
			outResult <= '0;
		end
		else
		begin
			outVld <= scoreVld;
			outScores <= scoreVec;
			outResult <= best;
		end
	end

	// A registered score above the winner, or equal to it from a lower index
	always_comb
	begin
		betterScore = 1'b0;
		for (int i = 0; i < `NUM_CLASSES; i++)
		begin
			if ((outScores[i] > outResult.classScore) ||
				(i < int'(outResult.classIdx) && outScores[i] == outResult.classScore))
			begin
				betterScore = 1'b1;
			end
		end
	end

	// Winner names a real class and holds the highest score
	resultConsistent: assert property (@(posedge clk) disable iff (reset)
		outVld |-> (int'(outResult.classIdx) < `NUM_CLASSES) &&
			(outScores[outResult.classIdx] == outResult.classScore) && !betterScore)
		else $error("class %0d is not the highest score", outResult.classIdx);

endmodule

// ==== logic/mlpClassifier.sv ====
`timescale 1ns/1ps
`include "classifier_settings.svh"

module mlpClassifier
	import nnTypesPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inVld,
	input featureVec_t inVec,
	output logic outVld,
	output scoreVec_t outScores,
	output classResult_t outResult
);

	logic capVld;
	featureVec_t capVec;
	logic hidVld;
	hiddenVec_t hidVec;
	logic scoreVld;
	scoreVec_t scoreVec;

	featureCapture uCapture (
		.clk(clk),
		.reset(reset),
		.inVld(inVld),
		.inVec(inVec),
		.capVld(capVld),
		.capVec(capVec)
	);

	denseLayer #(
		.NUM_IN(`NUM_FEATURES),
		.NUM_OUT(`NUM_HIDDEN),
		.OUT_LAYER(1'b0)
	) uHidden (
		.clk(clk),
		.reset(reset),
		.layerVldIn(capVld),
		.layerIn(capVec),
		.layerVldOut(hidVld),
		.layerOut(hidVec)
	);

	denseLayer #(
		.NUM_IN(`NUM_HIDDEN),
		.NUM_OUT(`NUM_CLASSES),
		.OUT_LAYER(1'b1)
	) uOutput (
		.clk(clk),
		.reset(reset),
		.layerVldIn(hidVld),
		.layerIn(hidVec),
		.layerVldOut(scoreVld),
		.layerOut(scoreVec)
	);

	argmaxSelect uArgmax (
		.clk(clk),
		.reset(reset),
		.scoreVld(scoreVld),
		.scoreVec(scoreVec),
		.outVld(outVld),
		.outScores(outScores),
		.outResult(outResult)
	);

endmodule

// ==== dv/mlpClassifierTb.sv ====
`timescale 1ns/1ps
`include "classifier_settings.svh"

module mlpClassifierTb
	import nnTypesPkg::*;
	import nnWeightsPkg::*;
();

	// Capture, two layers and argmax
	localparam int PIPE_LATENCY = 2 + 2 * `NODE_LATENCY;
	localparam int DRAIN_LIMIT = 4 * PIPE_LATENCY;
	localparam int SAT_SUM = 8192;

	logic clk;
	logic reset;
	logic inVld;
	featureVec_t inVec;
	logic outVld;
	scoreVec_t outScores;
	classResult_t outResult;

	integer seed;
	int cycle = 0;
	int tiesSent;

	// Expected results in send order
	scoreVec_t expScoresQ[$];
	classResult_t expResultQ[$];
	int sentCycleQ[$];

	mlpClassifier i_dut (
		.clk(clk),
		.reset(reset),
		.inVld(inVld),
		.inVec(inVec),
		.outVld(outVld),
		.outScores(outScores),
		.outResult(outResult)
	);

	always #10 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// Rectify, saturate at 8192, otherwise divide by 64 with round half up
	function automatic act_t activate(input int sum);
		if (sum < 0)
		begin
			return '0;
		end
		else if (sum >= SAT_SUM)
		begin
			return act_t'(127);
		end
		else
		begin
			return act_t'((sum >>> 6) + ((sum >>> 5) & 1));
		end
	endfunction

	function automatic hiddenVec_t hiddenLayer(input featureVec_t v);
		hiddenVec_t h;
		int sum;
		for (int n = 0; n < `NUM_HIDDEN; n++)
		begin
			sum = int'($signed(hiddenBias[n]));
			for (int i = 0; i < `NUM_FEATURES; i++)
			begin
				sum += int'(v[i]) * int'($signed(hiddenWeights[n][i]));
			end
			h[n] = activate(sum);
		end
		return h;
	endfunction

	// Hidden bytes are read as signed, 128 counts as -128
	function automatic scoreVec_t outputLayer(input hiddenVec_t h);
		scoreVec_t s;
		int sum;
		for (int c = 0; c < `NUM_CLASSES; c++)
		begin
			sum = int'($signed(outBias[c]));
			for (int i = 0; i < `NUM_HIDDEN; i++)
			begin
				sum += int'($signed(h[i])) * int'($signed(outWeights[c][i]));
			end
			s[c] = activate(sum);
		end
		return s;
	endfunction

	// Unsigned compare, first index holding the maximum wins
	function automatic classResult_t pickClass(input scoreVec_t s);
		classResult_t r;
		int maxScore;
		int maxIdx;
		maxScore = -1;
		maxIdx = 0;
		for (int c = 0; c < `NUM_CLASSES; c++)
		begin
			if (int'(s[c]) > maxScore)
			begin
				maxScore = int'(s[c]);
				maxIdx = c;
			end
		end
		r.classIdx = classIdx_t'(maxIdx);
		r.classScore = act_t'(maxScore);
		return r;
	endfunction

	function automatic bit topTied(input scoreVec_t s);
		int maxScore;
		int count;
		maxScore = 0;
		count = 0;
		for (int c = 0; c < `NUM_CLASSES; c++)
		begin
			if (int'(s[c]) > maxScore)
				maxScore = int'(s[c]);
		end
		for (int c = 0; c < `NUM_CLASSES; c++)
		begin
			if (int'(s[c]) == maxScore)
				count++;
		end
		return count >= 2;
	endfunction

	function automatic featureVec_t randomVector();
		featureVec_t v;
		for (int i = 0; i < `NUM_FEATURES; i++)
		begin
			v[i] = feature_t'($random(seed));
		end
		return v;
	endfunction

	// Even elements take a, odd elements take b
	function automatic featureVec_t patternVector(input feature_t a, input feature_t b);
		featureVec_t v;
		for (int i = 0; i < `NUM_FEATURES; i++)
		begin
			v[i] = (i % 2 == 0) ? a : b;
		end
		return v;
	endfunction

	task automatic abortRun();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkScores(input scoreVec_t got, input scoreVec_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: outScores got %h expected %h", $time, got, exp);
			abortRun();
		end
	endtask

	task automatic checkResult(input classResult_t got, input classResult_t exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: outResult got class %0d score %0d expected class %0d score %0d",
				$time, got.classIdx, got.classScore, exp.classIdx, exp.classScore);
			abortRun();
		end
	endtask

	task automatic recordInput(input featureVec_t v);
		scoreVec_t s;
		s = outputLayer(hiddenLayer(v));
		expScoresQ.push_back(s);
		expResultQ.push_back(pickClass(s));
		sentCycleQ.push_back(cycle);
	endtask

	task automatic checkOutputs();
		int age;
		age = (sentCycleQ.size() != 0) ? cycle - sentCycleQ[0] : 0;
		if (outVld === 1'b1)
		begin
			if (expScoresQ.size() == 0)
			begin
				$display("outVld went high at %0t with no input vector outstanding", $time);
				abortRun();
			end
			else if (age != PIPE_LATENCY)
			begin
				$display("outVld at %0t came %0d cycles after its input instead of %0d",
					$time, age, PIPE_LATENCY);
				abortRun();
			end
			else
			begin
				checkScores(outScores, expScoresQ.pop_front());
				checkResult(outResult, expResultQ.pop_front());
				void'(sentCycleQ.pop_front());
			end
		end
		else if (outVld !== 1'b0)
		begin
			$display("outVld is unknown at %0t", $time);
			abortRun();
		end
		else if (sentCycleQ.size() != 0 && age >= PIPE_LATENCY)
		begin
			$display("no result by %0t for the vector sent %0d cycles earlier", $time, age);
			abortRun();
		end
	endtask

	// Outputs and inputs are both stable at the falling edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			if (outVld !== 1'b0)
			begin
				$display("outVld is not low during reset at %0t", $time);
				abortRun();
			end
		end
		else
		begin
			checkOutputs();
			if (inVld === 1'b1)
				recordInput(inVec);
		end
	end

	task automatic sendVector(input featureVec_t v);
		@(posedge clk);
		inVld <= 1'b1;
		inVec <= v;
	endtask

	// Data keeps moving while the strobe is low
	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			inVld <= 1'b0;
			inVec <= randomVector();
		end
	endtask

	task automatic waitForDrain();
		int waited;
		waited = 0;
		idleCycles(1);
		while (expScoresQ.size() != 0 && waited < DRAIN_LIMIT)
		begin
			idleCycles(1);
			waited++;
		end
		if (expScoresQ.size() != 0)
		begin
			$display("timeout with %0d results still outstanding", expScoresQ.size());
			abortRun();
		end
	endtask

	initial
	begin
		featureVec_t v;
		int gap;
		seed = 16;
		tiesSent = 0;
		clk = 1'b0;
		reset = 1'b1;
		inVld = 1'b0;
		inVec = '0;

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// Quiet pipeline after reset
		idleCycles(PIPE_LATENCY + 2);

		// Single vectors with random gaps
		repeat (60)
		begin
			sendVector(randomVector());
			gap = int'({$random(seed)} % 12);
			idleCycles(gap);
		end
		waitForDrain();

		repeat (200) sendVector(randomVector());
		waitForDrain();

		// Saturation and negative clamping in the hidden layer
		sendVector(patternVector(8'sd127, 8'sd127));
		sendVector(patternVector(-8'sd128, -8'sd128));
		sendVector(patternVector(8'sd127, -8'sd128));
		sendVector(patternVector(-8'sd128, 8'sd127));
		sendVector(patternVector(8'sd64, -8'sd64));
		sendVector(patternVector(-8'sd1, 8'sd1));
		waitForDrain();

		// Zero input leaves only the biases
		sendVector('0);
		for (int k = 0; k < 20000 && tiesSent < 8; k++)
		begin
			v = randomVector();
			if (topTied(outputLayer(hiddenLayer(v))))
			begin
				sendVector(v);
				tiesSent++;
			end
		end
		if (tiesSent == 0)
		begin
			$display("no random vector gave a tie between two classes");
			abortRun();
		end
		waitForDrain();

		idleCycles(2 * PIPE_LATENCY);

		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+logic
logic/nnTypesPkg.sv
logic/nnWeightsPkg.sv
logic/featureCapture.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/argmaxSelect.sv
logic/mlpClassifier.sv
dv/mlpClassifierTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module mlpClassifierTb -o mlpClassifierTb

# The log decides pass or fail
./obj_dir/mlpClassifierTb > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
